// File: ctrl_pkg.sv
// shared types for the pipeline controller
// assumes jumps resolve in decode and EX is a separate stage
// encodings follow the fetch stage PC mux and the ID forwarding muxes
package ctrl_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int unsigned PC_SEL_W  = 3;
  localparam int unsigned JUMP_W    = 2;
  localparam int unsigned FWD_SEL_W = 2;

  //////////////////////////////
  // controller state
  //////////////////////////////

  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

  // pc source in the fetch stage
  // gaps in the encoding are sources this controller never selects
  typedef enum logic [PC_SEL_W-1:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100
  } pc_sel_e;

  // control transfer kind seen by the decoder
  typedef enum logic [JUMP_W-1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_kind_e;

  // operand source for the ID stage muxes
  typedef enum logic [FWD_SEL_W-1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

endpackage

// File: regfwd_if.sv
// write-back status of the later stages as seen from decode
// match bits are precomputed outside, so no register addresses travel here
`timescale 1ns/1ns

interface regfwd_if;

  // write enables from the later stages
  logic regfile_we_ex;
  logic regfile_we_wb;
  logic regfile_alu_we_fw;

  // EX currently holds a load
  logic data_req_ex;

  // destination of EX / ALU path equals decode source
  logic reg_d_alu_is_reg_a;
  logic reg_d_alu_is_reg_b;

  // destination of WB equals decode source
  logic reg_d_wb_is_reg_a;
  logic reg_d_wb_is_reg_b;

  // consumers only look at the bits
  modport sink (
    input regfile_we_ex,
    input regfile_we_wb,
    input regfile_alu_we_fw,
    input data_req_ex,
    input reg_d_alu_is_reg_a,
    input reg_d_alu_is_reg_b,
    input reg_d_wb_is_reg_a,
    input reg_d_wb_is_reg_b
  );

endinterface

// File: ctrl_fsm.sv
// main control FSM of the in-order pipeline
// outputs are combinational from state and inputs, only state and jump_done_q are flops
// a jump is issued once even if decode is held, jump_done_q clears with id_ready_i
// no debug support, no eret
`timescale 1ns/1ns

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  logic        fetch_enable_i,
  input  logic        instr_valid_i,
  input  logic        branch_taken_ex_i,
  input  jump_kind_e  jump_in_dec_i,
  input  logic        pipe_flush_i,
  input  logic        exc_req_i,
  input  logic        ext_req_i,
  input  logic        id_ready_i,
  input  logic        ex_valid_i,
  input  logic        jr_stall_i,

  output logic        ctrl_busy_o,
  output logic        is_decoding_o,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output logic        exc_ack_o,
  output logic        exc_save_if_o,
  output logic        exc_save_id_o,
  output logic        exc_save_takenbranch_o,
  output logic        halt_if_o,
  output logic        halt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set when a jump redirect goes out this cycle
  logic jump_done;
  logic jump_done_q;

  logic is_jump;

  // jal and jalr both redirect straight from decode
  assign is_jump = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb
  begin
    // defaults for a running core
    state_d                = state_q;
    ctrl_busy_o            = 1'b1;
    is_decoding_o          = 1'b0;
    instr_req_o            = 1'b1;
    pc_set_o               = 1'b0;
    pc_mux_o               = PC_BOOT;
    jump_done              = jump_done_q;
    exc_ack_o              = 1'b0;
    exc_save_if_o          = 1'b0;
    exc_save_id_o          = 1'b0;
    exc_save_takenbranch_o = 1'b0;
    halt_if_o              = 1'b0;
    halt_id_o              = 1'b0;

    unique case (state_q)
      // idle after reset until fetching is enabled
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address into the fetch PC, one cycle only
      BOOT_SET:
      begin
        pc_mux_o = PC_BOOT;
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // pipeline is empty, wake on enable or on an interrupt
      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach decode
      FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = DECODE;

        // nothing decoded yet, so the saved PC is the fetch PC
        if (exc_req_i)
        begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
        end
      end

      DECODE:
      begin
        // a taken branch in EX kills whatever sits in decode
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (is_jump)
          begin
            pc_mux_o = PC_JUMP;
            // hold off while the jalr base is pending, and never issue twice
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            // keep the current instruction out of EX
            pc_mux_o      = PC_EXCEPTION;
            pc_set_o      = 1'b1;
            exc_ack_o     = 1'b1;
            exc_save_id_o = 1'b1;
            halt_id_o     = 1'b1;
          end

          // wfi style flush, drain EX and WB
          if (pipe_flush_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // bubble in decode, external interrupt saves the fetch PC
        if (!instr_valid_i && !branch_taken_ex_i && ext_req_i)
        begin
          pc_mux_o      = PC_EXCEPTION;
          pc_set_o      = 1'b1;
          exc_ack_o     = 1'b1;
          exc_save_if_o = 1'b1;
          halt_id_o     = 1'b1;
        end

        //////////////////////////////
        // taken branch from EX
        //////////////////////////////
        if (branch_taken_ex_i)
        begin
          pc_mux_o      = PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;

          // interrupt on a taken branch resumes at the branch target
          if (ext_req_i)
          begin
            pc_mux_o               = PC_EXCEPTION;
            exc_ack_o              = 1'b1;
            exc_save_takenbranch_o = 1'b1;
            halt_id_o              = 1'b1;
          end
        end
      end

      // NOP goes into EX, wait until EX completes
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // last stage drains, then resume or sleep
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end
        else
        begin
          state_d = SLEEP;
        end
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////
  // state registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // remembered only while decode is held
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

// File: hazard_unit.sv
// load-use and jump-register hazard detection for the decode stage
// match bits come precomputed, operand C is not handled
`timescale 1ns/1ns

module hazard_unit
  import ctrl_pkg::*;
(
  input  logic          is_decoding_i,
  input  logic          illegal_insn_i,
  input  jump_kind_e    jump_in_dec_i,
  regfwd_if.sink        fw,

  output logic          load_stall_o,
  output logic          jr_stall_o,
  output logic          deassert_we_o
);

  logic ex_load_match;
  logic jalr_base_pending;

  // load in EX writes a register that decode reads
  assign ex_load_match = fw.data_req_ex && fw.regfile_we_ex &&
                         (fw.reg_d_alu_is_reg_a || fw.reg_d_alu_is_reg_b);

  // jalr base must come from the register file, not a bypass
  // EX and ALU share one destination match in this config
  assign jalr_base_pending =
    (fw.regfile_we_wb     && fw.reg_d_wb_is_reg_a)  ||
    (fw.regfile_we_ex     && fw.reg_d_alu_is_reg_a) ||
    (fw.regfile_alu_we_fw && fw.reg_d_alu_is_reg_a);

  always_comb
  begin
    load_stall_o = ex_load_match;
    jr_stall_o   = (jump_in_dec_i == BRANCH_JALR) && jalr_base_pending;

    // stalled, illegal or idle decode must not write back
    deassert_we_o = load_stall_o || jr_stall_o || illegal_insn_i || !is_decoding_i;
  end

endmodule

// File: fwd_unit.sv
// operand A/B bypass select for the decode stage
// EX result wins over WB, regfile otherwise
`timescale 1ns/1ns

module fwd_unit
  import ctrl_pkg::*;
(
  regfwd_if.sink        fw,

  output fwd_sel_e      operand_a_fw_mux_sel_o,
  output fwd_sel_e      operand_b_fw_mux_sel_o
);

  // same priority for both operands
  function automatic fwd_sel_e pick_src(input logic alu_hit, input logic wb_hit);
    fwd_sel_e sel;
    sel = SEL_REGFILE;
    if (wb_hit)
      sel = SEL_FW_WB;
    // youngest value is in EX
    if (alu_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  always_comb
  begin
    operand_a_fw_mux_sel_o = pick_src(fw.regfile_alu_we_fw && fw.reg_d_alu_is_reg_a,
                                      fw.regfile_we_wb && fw.reg_d_wb_is_reg_a);
    operand_b_fw_mux_sel_o = pick_src(fw.regfile_alu_we_fw && fw.reg_d_alu_is_reg_b,
                                      fw.regfile_we_wb && fw.reg_d_wb_is_reg_b);
  end

endmodule

// File: riscv_ctrl.sv
// controller top with plain ports for the ID stage
// jumps resolve in decode, EX is a separate stage
// no debug, eret, perf counters or misaligned stalls
`timescale 1ns/1ns

module riscv_ctrl
  import ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // run control
  input  logic        fetch_enable_i,
  output logic        ctrl_busy_o,
  output logic        is_decoding_o,

  // decoder
  input  logic        illegal_insn_i,
  input  logic        pipe_flush_i,
  input  logic        instr_valid_i,
  input  jump_kind_e  jump_in_dec_i,
  output logic        deassert_we_o,

  // fetch side
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,

  // EX side
  input  logic        branch_taken_ex_i,
  input  logic        data_req_ex_i,

  // exceptions
  input  logic        exc_req_i,
  input  logic        ext_req_i,
  output logic        exc_ack_o,
  output logic        exc_save_if_o,
  output logic        exc_save_id_o,
  output logic        exc_save_takenbranch_o,

  // later stage write status
  input  logic        regfile_we_ex_i,
  input  logic        regfile_we_wb_i,
  input  logic        regfile_alu_we_fw_i,
  input  logic        reg_d_alu_is_reg_a_i,
  input  logic        reg_d_alu_is_reg_b_i,
  input  logic        reg_d_wb_is_reg_a_i,
  input  logic        reg_d_wb_is_reg_b_i,

  // bypass selects
  output fwd_sel_e    operand_a_fw_mux_sel_o,
  output fwd_sel_e    operand_b_fw_mux_sel_o,

  // stalls
  output logic        halt_if_o,
  output logic        halt_id_o,
  output logic        jr_stall_o,
  output logic        load_stall_o,

  // stage completion levels
  input  logic        id_ready_i,
  input  logic        ex_valid_i
);

  // between FSM and hazard unit
  logic is_decoding;
  logic jr_stall;

  regfwd_if fw ();

  //////////////////////////////
  // bundle the write status
  //////////////////////////////

  assign fw.regfile_we_ex      = regfile_we_ex_i;
  assign fw.regfile_we_wb      = regfile_we_wb_i;
  assign fw.regfile_alu_we_fw  = regfile_alu_we_fw_i;
  assign fw.data_req_ex        = data_req_ex_i;
  assign fw.reg_d_alu_is_reg_a = reg_d_alu_is_reg_a_i;
  assign fw.reg_d_alu_is_reg_b = reg_d_alu_is_reg_b_i;
  assign fw.reg_d_wb_is_reg_a  = reg_d_wb_is_reg_a_i;
  assign fw.reg_d_wb_is_reg_b  = reg_d_wb_is_reg_b_i;

  // internal handshake is visible to the ID stage as well
  assign is_decoding_o = is_decoding;
  assign jr_stall_o    = jr_stall;

  ctrl_fsm u_fsm (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .fetch_enable_i         (fetch_enable_i),
    .instr_valid_i          (instr_valid_i),
    .branch_taken_ex_i      (branch_taken_ex_i),
    .jump_in_dec_i          (jump_in_dec_i),
    .pipe_flush_i           (pipe_flush_i),
    .exc_req_i              (exc_req_i),
    .ext_req_i              (ext_req_i),
    .id_ready_i             (id_ready_i),
    .ex_valid_i             (ex_valid_i),
    .jr_stall_i             (jr_stall),
    .ctrl_busy_o            (ctrl_busy_o),
    .is_decoding_o          (is_decoding),
    .instr_req_o            (instr_req_o),
    .pc_set_o               (pc_set_o),
    .pc_mux_o               (pc_mux_o),
    .exc_ack_o              (exc_ack_o),
    .exc_save_if_o          (exc_save_if_o),
    .exc_save_id_o          (exc_save_id_o),
    .exc_save_takenbranch_o (exc_save_takenbranch_o),
    .halt_if_o              (halt_if_o),
    .halt_id_o              (halt_id_o)
  );

  hazard_unit u_hazard (
    .is_decoding_i  (is_decoding),
    .illegal_insn_i (illegal_insn_i),
    .jump_in_dec_i  (jump_in_dec_i),
    .fw             (fw.sink),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall),
    .deassert_we_o  (deassert_we_o)
  );

  fwd_unit u_fwd (
    .fw                     (fw.sink),
    .operand_a_fw_mux_sel_o (operand_a_fw_mux_sel_o),
    .operand_b_fw_mux_sel_o (operand_b_fw_mux_sel_o)
  );

endmodule

// File: tb_riscv_ctrl.sv
// testbench for the pipeline controller with checks as concurrent assertions
// inputs change 10 ns after the rising edge and assertions sample on the rising edge
// decode stage is reached by the boot test and kept for the later tests
`timescale 1ns/1ns

module tb_riscv_ctrl
  import ctrl_pkg::*;
;

  localparam int MAX_CYCLES = 2000;
  localparam int T_BOOT  = 1;
  localparam int T_JUMP  = 2;
  localparam int T_HAZ   = 3;
  localparam int T_FWD   = 4;
  localparam int T_EXC   = 5;
  localparam int T_FLUSH = 6;

  logic clk;
  logic rst_n;
  logic fetch_enable_i, illegal_insn_i, pipe_flush_i, instr_valid_i;
  logic branch_taken_ex_i, data_req_ex_i, exc_req_i, ext_req_i;
  logic regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i;
  logic reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i;
  logic id_ready_i, ex_valid_i;
  jump_kind_e jump_in_dec_i;

  logic ctrl_busy_o, is_decoding_o, deassert_we_o, instr_req_o, pc_set_o;
  logic exc_ack_o, exc_save_if_o, exc_save_id_o, exc_save_takenbranch_o;
  logic halt_if_o, halt_id_o, jr_stall_o, load_stall_o;
  pc_sel_e  pc_mux_o;
  fwd_sel_e operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o;

  int test_id;
  int err_count;
  int tests_passed;
  int tests_failed;
  int cycle_count;

  riscv_ctrl uut (.*);

  //////////////////////////////
  // reference model
  //////////////////////////////

  logic exp_load_stall, exp_jr_stall, exp_decoding, jump_expected, jump_held_q;
  fwd_sel_e exp_sel_a, exp_sel_b;
  // 0 idle, 1 flush EX, 2 flush WB, 3 asleep
  logic [1:0] flush_stage;

  assign exp_load_stall = data_req_ex_i && regfile_we_ex_i &&
                          (reg_d_alu_is_reg_a_i || reg_d_alu_is_reg_b_i);
  // jalr base must not be in flight anywhere
  assign exp_jr_stall = (jump_in_dec_i == BRANCH_JALR) &&
                        ((regfile_we_wb_i && reg_d_wb_is_reg_a_i) ||
                         (regfile_we_ex_i && reg_d_alu_is_reg_a_i) ||
                         (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i));
  assign exp_decoding = instr_valid_i && !branch_taken_ex_i;

  // EX match first, then WB, then regfile
  assign exp_sel_a = (regfile_alu_we_fw_i && reg_d_alu_is_reg_a_i) ? SEL_FW_EX :
                     (regfile_we_wb_i && reg_d_wb_is_reg_a_i) ? SEL_FW_WB : SEL_REGFILE;
  assign exp_sel_b = (regfile_alu_we_fw_i && reg_d_alu_is_reg_b_i) ? SEL_FW_EX :
                     (regfile_we_wb_i && reg_d_wb_is_reg_b_i) ? SEL_FW_WB : SEL_REGFILE;

  // a redirect is due for jal, or for jalr without a pending base
  assign jump_expected = (test_id == T_JUMP || test_id == T_HAZ) && exp_decoding &&
                         !jump_held_q && ((jump_in_dec_i == BRANCH_JAL) ||
                         (jump_in_dec_i == BRANCH_JALR && !exp_jr_stall));

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      jump_held_q <= 1'b0;
      flush_stage <= 2'd0;
    end
    else
    begin
      // issued jump stays remembered while decode is held
      jump_held_q <= (jump_held_q || jump_expected) && !id_ready_i;
      case (flush_stage)
        2'd0: if (test_id == T_FLUSH && pipe_flush_i && exp_decoding) flush_stage <= 2'd1;
        2'd1: if (ex_valid_i) flush_stage <= 2'd2;
        2'd2: flush_stage <= fetch_enable_i ? 2'd0 : 2'd3;
        default: if (fetch_enable_i || exc_req_i) flush_stage <= 2'd0;
      endcase
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic log_failure(input string msg);
    err_count++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // RESET holds through the reset cycles until fetch is enabled
  a_reset_idle: assert property (@(posedge clk)
    (test_id == T_BOOT && !fetch_enable_i) |-> (!ctrl_busy_o && !instr_req_o && !pc_set_o))
    else log_failure("controller active before fetch enable");
  a_boot_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_BOOT && fetch_enable_i && !$past(fetch_enable_i)) |-> !pc_set_o)
    else log_failure("pc_set_o in the cycle fetch enable was sampled");
  a_boot_set: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_BOOT && $past(fetch_enable_i) && !$past(fetch_enable_i, 2))
    |-> (pc_set_o && pc_mux_o == PC_BOOT))
    else log_failure("no boot address load one cycle after fetch enable");
  a_boot_once: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_BOOT && $past(fetch_enable_i, 2) && !$past(fetch_enable_i, 3)) |-> !pc_set_o)
    else log_failure("boot pc_set_o longer than one cycle");

  a_jump_issue: assert property (@(posedge clk) disable iff (!rst_n)
    jump_expected |-> (pc_set_o && pc_mux_o == PC_JUMP))
    else log_failure("jump in decode not redirected");
  a_jump_once: assert property (@(posedge clk) disable iff (!rst_n)
    jump_held_q |-> !(pc_set_o && pc_mux_o == PC_JUMP))
    else log_failure("jump redirected twice while decode held");

  a_load_stall: assert property (@(posedge clk) disable iff (!rst_n)
    load_stall_o == exp_load_stall)
    else log_failure("load_stall_o differs from the load-use rule");
  a_jr_stall: assert property (@(posedge clk) disable iff (!rst_n)
    jr_stall_o == exp_jr_stall)
    else log_failure("jr_stall_o differs from the jalr base rule");
  a_jr_no_jump: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_HAZ && exp_jr_stall) |-> !pc_set_o)
    else log_failure("stalled jalr raised pc_set_o");
  a_decoding: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_HAZ) |-> (is_decoding_o == exp_decoding))
    else log_failure("is_decoding_o wrong in decode");
  a_deassert: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_HAZ) |-> (deassert_we_o ==
      (exp_load_stall || exp_jr_stall || illegal_insn_i || !exp_decoding)))
    else log_failure("deassert_we_o wrong");

  a_fwd_a: assert property (@(posedge clk) disable iff (!rst_n)
    operand_a_fw_mux_sel_o == exp_sel_a)
    else log_failure("operand A forward select wrong");
  a_fwd_b: assert property (@(posedge clk) disable iff (!rst_n)
    operand_b_fw_mux_sel_o == exp_sel_b)
    else log_failure("operand B forward select wrong");

  a_exc_branch: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_EXC && branch_taken_ex_i && ext_req_i)
    |-> (pc_set_o && pc_mux_o == PC_EXCEPTION && exc_ack_o && exc_save_takenbranch_o))
    else log_failure("interrupt on taken branch not taken");
  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_EXC && branch_taken_ex_i && !ext_req_i)
    |-> (pc_set_o && pc_mux_o == PC_BRANCH && !exc_ack_o))
    else log_failure("taken branch not redirected");
  a_exc_id: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_EXC && exc_req_i && exp_decoding && jump_in_dec_i == BRANCH_NONE)
    |-> (pc_set_o && pc_mux_o == PC_EXCEPTION && exc_ack_o && exc_save_id_o && halt_id_o))
    else log_failure("exception on decoded instruction not taken");
  // bubble in decode saves the fetch PC
  a_exc_if: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_EXC && !instr_valid_i && !branch_taken_ex_i && ext_req_i)
    |-> (pc_set_o && pc_mux_o == PC_EXCEPTION && exc_ack_o && exc_save_if_o))
    else log_failure("interrupt on a decode bubble not taken");

  a_flush_halt: assert property (@(posedge clk) disable iff (!rst_n)
    (test_id == T_FLUSH && flush_stage == 2'd0 && pipe_flush_i && exp_decoding)
    |-> (halt_if_o && halt_id_o))
    else log_failure("pipe flush did not halt IF and ID");
  a_flush_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (flush_stage == 2'd1 || (flush_stage == 2'd2 && !fetch_enable_i))
    |-> (halt_if_o && halt_id_o && ctrl_busy_o))
    else log_failure("stages not halted during flush");
  a_sleep: assert property (@(posedge clk) disable iff (!rst_n)
    (flush_stage == 2'd3) |-> (!ctrl_busy_o && !instr_req_o))
    else log_failure("controller busy while asleep");

  //////////////////////////////
  // clock and timeout
  //////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic clear_stimulus();
    illegal_insn_i = 1'b0;
    pipe_flush_i = 1'b0;
    instr_valid_i = 1'b0;
    jump_in_dec_i = BRANCH_NONE;
    branch_taken_ex_i = 1'b0;
    exc_req_i = 1'b0;
    ext_req_i = 1'b0;
    ex_valid_i = 1'b0;
    data_req_ex_i = 1'b0;
    regfile_we_ex_i = 1'b0;
    regfile_we_wb_i = 1'b0;
    regfile_alu_we_fw_i = 1'b0;
    reg_d_alu_is_reg_a_i = 1'b0;
    reg_d_alu_is_reg_b_i = 1'b0;
    reg_d_wb_is_reg_a_i = 1'b0;
    reg_d_wb_is_reg_b_i = 1'b0;
  endtask

  // random write status of the later stages
  task automatic randomize_status();
    logic [31:0] rnd;
    rnd = $urandom();
    regfile_we_ex_i = rnd[0];
    regfile_we_wb_i = rnd[1];
    regfile_alu_we_fw_i = rnd[2];
    data_req_ex_i = rnd[3];
    reg_d_alu_is_reg_a_i = rnd[4];
    reg_d_alu_is_reg_b_i = rnd[5];
    reg_d_wb_is_reg_a_i = rnd[6];
    reg_d_wb_is_reg_b_i = rnd[7];
  endtask

  task automatic report_test(input string name, input int errs_before);
    // let the last sampled edge settle its checks
    next_cycle();
    if (err_count == errs_before)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d failing checks", name, err_count - errs_before);
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic boot_after_reset();
    int errs;
    errs = err_count;
    test_id = T_BOOT;
    repeat (16) next_cycle();
    rst_n = 1'b1;
    repeat (3) next_cycle();
    fetch_enable_i = 1'b1;
    id_ready_i = 1'b1;
    // RESET, BOOT_SET, FIRST_FETCH, then DECODE
    repeat (5) next_cycle();
    report_test("reset and boot", errs);
  endtask

  task automatic jump_while_held();
    int errs;
    errs = err_count;
    test_id = T_JUMP;
    instr_valid_i = 1'b1;
    jump_in_dec_i = BRANCH_JAL;
    id_ready_i = 1'b0;
    repeat (5) next_cycle();
    // released decode lets the next jal redirect again
    id_ready_i = 1'b1;
    repeat (3) next_cycle();
    clear_stimulus();
    report_test("jump issued once", errs);
  endtask

  task automatic hazard_sweep();
    int errs;
    logic [31:0] rnd;
    errs = err_count;
    test_id = T_HAZ;
    repeat (200)
    begin
      randomize_status();
      rnd = $urandom();
      jump_in_dec_i = jump_kind_e'(rnd[1:0]);
      instr_valid_i = rnd[2] | rnd[3];
      illegal_insn_i = rnd[4] & rnd[5];
      next_cycle();
    end
    clear_stimulus();
    report_test("hazards", errs);
  endtask

  task automatic forward_sweep();
    int errs;
    errs = err_count;
    test_id = T_FWD;
    repeat (200)
    begin
      randomize_status();
      next_cycle();
    end
    clear_stimulus();
    report_test("forwarding", errs);
  endtask

  task automatic exception_cases();
    int errs;
    errs = err_count;
    test_id = T_EXC;
    instr_valid_i = 1'b1;
    branch_taken_ex_i = 1'b1;
    ext_req_i = 1'b1;
    next_cycle();
    ext_req_i = 1'b0;
    next_cycle();
    branch_taken_ex_i = 1'b0;
    exc_req_i = 1'b1;
    next_cycle();
    // interrupt while decode holds a bubble
    instr_valid_i = 1'b0;
    exc_req_i = 1'b0;
    ext_req_i = 1'b1;
    next_cycle();
    clear_stimulus();
    report_test("exceptions", errs);
  endtask

  task automatic flush_sleep_wake();
    int errs;
    int n;
    logic seen;
    errs = err_count;
    test_id = T_FLUSH;
    instr_valid_i = 1'b1;
    pipe_flush_i = 1'b1;
    next_cycle();
    clear_stimulus();
    fetch_enable_i = 1'b0;
    // EX may take a while
    repeat (4) next_cycle();
    ex_valid_i = 1'b1;
    next_cycle();
    ex_valid_i = 1'b0;
    repeat (4) next_cycle();
    exc_req_i = 1'b1;
    n = 0;
    seen = 1'b0;
    while (!seen && n < 10)
    begin
      @(negedge clk);
      seen = ctrl_busy_o;
      n++;
    end
    if (!seen)
    begin
      err_count++;
      $display("controller did not wake up after the exception request at %0t", $time);
    end
    next_cycle();
    exc_req_i = 1'b0;
    report_test("flush, sleep and wake", errs);
  endtask

  initial
  begin
    void'($urandom(45265));
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count = 0;
    test_id = T_BOOT;
    rst_n = 1'b0;
    fetch_enable_i = 1'b0;
    id_ready_i = 1'b0;
    clear_stimulus();

    boot_after_reset();
    jump_while_held();
    hazard_sweep();
    forward_sweep();
    exception_cases();
    flush_sleep_wake();

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: all.f
ctrl_pkg.sv
regfwd_if.sv
ctrl_fsm.sv
hazard_unit.sv
fwd_unit.sv
riscv_ctrl.sv
tb_riscv_ctrl.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and pass only when the pass line is printed
verilator --binary --timing --assert -f all.f --top-module tb_riscv_ctrl -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
